//--- include/dp_settings.svh
`ifndef DP_SETTINGS_SVH
`define DP_SETTINGS_SVH

// datapath width, fixed by the instruction set
`define DP_WORD_WIDTH 32

`define DP_WB_ADR_WIDTH 3 // word address into the register map

// immediate shift amounts only, so 0 to 31
`define DP_SHAMT_WIDTH 5

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register map, word addresses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define DP_ADR_OP_A   3'd0
`define DP_ADR_OP_B   3'd1
`define DP_ADR_SHIFT  3'd2
`define DP_ADR_CMD    3'd3 // a write here runs the datapath
`define DP_ADR_RESULT 3'd4
`define DP_ADR_FLAGS  3'd5 // nzcv in bits 31 to 28

`endif

//--- verilog/dp_pkg.sv
`default_nettype none

`include "dp_settings.svh"

package dp_pkg;

  typedef logic [`DP_WORD_WIDTH-1:0] word_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // datapath control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [3:0] {
    ALU_OP_MOV            = 4'd0,
    ALU_OP_NOT            = 4'd1,
    ALU_OP_AND            = 4'd2,
    ALU_OP_TEST           = 4'd3,
    ALU_OP_XOR            = 4'd4,
    ALU_OP_TEST_EXCLUSIVE = 4'd5,
    ALU_OP_OR             = 4'd6,
    ALU_OP_BIT_CLEAR      = 4'd7,
    ALU_OP_ADD            = 4'd8,
    ALU_OP_CMP_NEG        = 4'd9,
    ALU_OP_ADC            = 4'd10,
    ALU_OP_SUB            = 4'd11,
    ALU_OP_CMP            = 4'd12,
    ALU_OP_SBC            = 4'd13,
    ALU_OP_SUB_REVERSED   = 4'd14,
    ALU_OP_SBC_REVERSED   = 4'd15
  } alu_op_e;

  typedef enum logic [2:0] {
    SHIFT_LSL = 3'd0,
    SHIFT_LSR = 3'd1,
    SHIFT_ASR = 3'd2,
    SHIFT_ROR = 3'd3,
    SHIFT_RRX = 3'd4 // amount is ignored
  } shift_type_e;

  typedef struct packed {
    shift_type_e                  shift_type;
    logic [`DP_SHAMT_WIDTH-1:0]   amount;
  } shift_ctrl_t;

  // command word as written to CMD, alu_op in bits 3 to 0
  typedef struct packed {
    logic    spare;
    logic    disable_op_b;
    logic    use_op_b_latch;
    logic    latch_op_b;
    alu_op_e alu_op;
  } dp_cmd_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // wishbone classic
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic                        cyc;
    logic                        stb;
    logic                        we;
    logic [`DP_WB_ADR_WIDTH-1:0] adr;
    word_t                       dat;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    word_t dat;
  } wb_rsp_t;

endpackage : dp_pkg

`default_nettype wire

//--- verilog/barrel_shifter.sv
`timescale 1ns/1ns
`default_nettype none

`include "dp_settings.svh"

module barrel_shifter (
  input  wire dp_pkg::word_t       op_b_raw,
  input  wire dp_pkg::shift_ctrl_t shift,
  input  wire                      carry_in,
  output dp_pkg::word_t            op_b,
  output logic                     carry_out
);

  import dp_pkg::*;

  localparam int W = `DP_WORD_WIDTH;

  logic [W:0]     lsl_ext; // carry in the top bit
  logic [W:0]     lsr_ext; // carry in the bottom bit
  logic [W:0]     asr_ext;
  logic [2*W-1:0] ror_ext;
  logic           amount_zero;

  assign amount_zero = (shift.amount == '0);

  // the carry-out lands in the extra bit, the last one shifted out
  assign lsl_ext = {1'b0, op_b_raw} << shift.amount;
  assign lsr_ext = {op_b_raw, 1'b0} >> shift.amount;
  assign asr_ext = $signed({op_b_raw, 1'b0}) >>> shift.amount;
  assign ror_ext = {op_b_raw, op_b_raw} >> shift.amount;

  always_comb begin
    // zero amount and unused type codes pass through
    op_b      = op_b_raw;
    carry_out = carry_in;

    case (shift.shift_type)
      SHIFT_LSL: begin
        if (!amount_zero) begin
          op_b      = lsl_ext[W-1:0];
          carry_out = lsl_ext[W];
        end
      end

      SHIFT_LSR: begin
        if (!amount_zero) begin
          op_b      = lsr_ext[W:1];
          carry_out = lsr_ext[0];
        end
      end

      SHIFT_ASR: begin
        if (!amount_zero) begin
          op_b      = asr_ext[W:1];
          carry_out = asr_ext[0];
        end
      end

      SHIFT_ROR: begin
        if (!amount_zero) begin
          op_b      = ror_ext[W-1:0];
          carry_out = ror_ext[W-1]; // last bit rotated out ends up on top
        end
      end

      SHIFT_RRX: begin
        op_b      = {carry_in, op_b_raw[W-1:1]}; // 33-bit rotate through carry
        carry_out = op_b_raw[0];
      end

      default: begin
        op_b      = op_b_raw;
        carry_out = carry_in;
      end
    endcase
  end

endmodule : barrel_shifter

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "dp_settings.svh"

module alu (
  input  wire                  clk,
  input  wire                  reset,
  input  wire                  issue,
  input  wire dp_pkg::dp_cmd_t cmd,
  input  wire dp_pkg::word_t   op_a,
  input  wire dp_pkg::word_t   op_b_shifted,
  input  wire                  shifter_carry,
  input  wire dp_pkg::nzcv_t   flags_in,
  output dp_pkg::word_t        result,
  output dp_pkg::nzcv_t        flags_out,
  output logic                 write_result
);

  import dp_pkg::*;

  localparam int MSB = `DP_WORD_WIDTH - 1;

  word_t            op_b;
  word_t            op_b_latch;
  logic [MSB+1:0]   sum; // one extra bit for carry or borrow

  // latch wins over disable
  assign op_b = cmd.use_op_b_latch ? op_b_latch :
                (cmd.disable_op_b ? '0 : op_b_shifted);

  always_ff @(posedge clk) begin
    if (reset) begin
      op_b_latch <= '0;
    end else if (issue && cmd.latch_op_b) begin
      op_b_latch <= op_b_shifted; // the shifter output, not the selected operand
    end
  end

  // compares and tests only touch the flags
  assign write_result = !(cmd.alu_op inside {ALU_OP_TEST, ALU_OP_TEST_EXCLUSIVE,
                                             ALU_OP_CMP, ALU_OP_CMP_NEG});

  always_comb begin
    sum         = '0;
    result      = '0;
    flags_out   = flags_in;
    flags_out.c = shifter_carry;

    unique case (cmd.alu_op)
      ALU_OP_MOV:                        result = op_b;
      ALU_OP_NOT:                        result = ~op_b;
      ALU_OP_AND, ALU_OP_TEST:           result = op_a & op_b;
      ALU_OP_XOR, ALU_OP_TEST_EXCLUSIVE: result = op_a ^ op_b;
      ALU_OP_OR:                         result = op_a | op_b;
      ALU_OP_BIT_CLEAR:                  result = op_a & ~op_b;

      ALU_OP_ADD, ALU_OP_CMP_NEG, ALU_OP_ADC: begin
        sum = {1'b0, op_a} + {1'b0, op_b};
        if (cmd.alu_op == ALU_OP_ADC) begin
          sum = sum + {{(MSB+1){1'b0}}, flags_in.c};
        end
        result      = sum[MSB:0];
        flags_out.c = sum[MSB+1];
        flags_out.v = ~(op_a[MSB] ^ op_b[MSB]) & (op_a[MSB] ^ result[MSB]);
      end

      ALU_OP_SUB, ALU_OP_CMP, ALU_OP_SBC: begin
        sum = {1'b0, op_a} - {1'b0, op_b};
        if (cmd.alu_op == ALU_OP_SBC) begin
          sum = sum - {{(MSB+1){1'b0}}, ~flags_in.c}; // extra one when C is clear
        end
        result      = sum[MSB:0];
        flags_out.c = ~sum[MSB+1]; // C means no borrow
        flags_out.v = (op_a[MSB] ^ op_b[MSB]) & (op_a[MSB] ^ result[MSB]);
      end

      ALU_OP_SUB_REVERSED, ALU_OP_SBC_REVERSED: begin
        sum = {1'b0, op_b} - {1'b0, op_a};
        if (cmd.alu_op == ALU_OP_SBC_REVERSED) begin
          sum = sum - {{(MSB+1){1'b0}}, ~flags_in.c};
        end
        result      = sum[MSB:0];
        flags_out.c = ~sum[MSB+1];
        flags_out.v = (op_a[MSB] ^ op_b[MSB]) & (op_b[MSB] ^ result[MSB]);
      end
    endcase

    flags_out.n = result[MSB];
    flags_out.z = (result == '0);
  end

endmodule : alu

`default_nettype wire

//--- verilog/dp_wb_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "dp_settings.svh"

module dp_wb_regs (
  input  wire                  clk,
  input  wire                  reset,
  input  wire dp_pkg::wb_req_t wb_req,
  output dp_pkg::wb_rsp_t      wb_rsp,
  output dp_pkg::word_t        op_a,
  output dp_pkg::word_t        op_b_raw,
  output dp_pkg::shift_ctrl_t  shift,
  output dp_pkg::dp_cmd_t      cmd,
  output dp_pkg::nzcv_t        flags,
  output logic                 issue,
  input  wire dp_pkg::word_t   result,
  input  wire dp_pkg::nzcv_t   flags_out,
  input  wire                  write_result
);

  import dp_pkg::*;

  logic  ack;
  logic  req_new; // request seen with no ack pending
  logic  wr;
  word_t result_q;
  word_t rd_data;

  assign req_new = wb_req.cyc & wb_req.stb & ~ack;
  assign wr      = req_new & wb_req.we;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // handshake and command issue
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (reset) begin
      ack   <= 1'b0;
      issue <= 1'b0;
    end else begin
      ack   <= req_new;
      issue <= wr && (wb_req.adr == `DP_ADR_CMD); // lines up with the ack cycle
    end
  end

  // host registers load as ack goes high, so cmd is stable while issue is high
  always_ff @(posedge clk) begin
    if (reset) begin
      op_a     <= '0;
      op_b_raw <= '0;
      shift    <= '0;
      cmd      <= '0;
    end else if (wr) begin
      case (wb_req.adr)
        `DP_ADR_OP_A:  op_a     <= wb_req.dat;
        `DP_ADR_OP_B:  op_b_raw <= wb_req.dat;
        `DP_ADR_SHIFT: shift    <= shift_ctrl_t'(wb_req.dat[$bits(shift_ctrl_t)-1:0]);
        `DP_ADR_CMD:   cmd      <= dp_cmd_t'(wb_req.dat[$bits(dp_cmd_t)-1:0]);
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      result_q <= '0;
      flags    <= '0;
    end else if (issue) begin
      if (write_result) result_q <= result;
      flags <= flags_out;
    end else if (wr && wb_req.adr == `DP_ADR_FLAGS) begin
      flags <= nzcv_t'(wb_req.dat[`DP_WORD_WIDTH-1 -: 4]); // host presets the carry
    end
  end

  always_comb begin
    case (wb_req.adr)
      `DP_ADR_OP_A:   rd_data = op_a;
      `DP_ADR_OP_B:   rd_data = op_b_raw;
      `DP_ADR_SHIFT:  rd_data = word_t'(shift);
      `DP_ADR_CMD:    rd_data = word_t'(cmd);
      `DP_ADR_RESULT: rd_data = result_q;
      `DP_ADR_FLAGS:  rd_data = {flags, {(`DP_WORD_WIDTH-4){1'b0}}};
      default:        rd_data = '0;
    endcase
  end

  assign wb_rsp = {ack, rd_data};

endmodule : dp_wb_regs

`default_nettype wire

//--- verilog/dp_unit_top.sv
`timescale 1ns/1ns
`default_nettype none

module dp_unit_top (
  input  wire                  clk,
  input  wire                  reset,
  input  wire dp_pkg::wb_req_t wb_req,
  output dp_pkg::wb_rsp_t      wb_rsp
);

  import dp_pkg::*;

  word_t       op_a;
  word_t       op_b_raw;
  word_t       op_b;
  shift_ctrl_t shift;
  dp_cmd_t     cmd;
  nzcv_t       flags;
  nzcv_t       flags_out;
  logic        issue;
  logic        shifter_carry;
  word_t       result;
  logic        write_result;

  dp_wb_regs regs (
    .clk          (clk),
    .reset        (reset),
    .wb_req       (wb_req),
    .wb_rsp       (wb_rsp),
    .op_a         (op_a),
    .op_b_raw     (op_b_raw),
    .shift        (shift),
    .cmd          (cmd),
    .flags        (flags),
    .issue        (issue),
    .result       (result),
    .flags_out    (flags_out),
    .write_result (write_result)
  );

  // RRX rotates the stored C flag in
  barrel_shifter shifter (
    .op_b_raw  (op_b_raw),
    .shift     (shift),
    .carry_in  (flags.c),
    .op_b      (op_b),
    .carry_out (shifter_carry)
  );

  alu alu_i (
    .clk           (clk),
    .reset         (reset),
    .issue         (issue),
    .cmd           (cmd),
    .op_a          (op_a),
    .op_b_shifted  (op_b),
    .shifter_carry (shifter_carry),
    .flags_in      (flags),
    .result        (result),
    .flags_out     (flags_out),
    .write_result  (write_result)
  );

endmodule : dp_unit_top

`default_nettype wire

//--- sim/dp_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "dp_settings.svh"

module dp_unit_tb;

  import dp_pkg::*;

  localparam int unsigned SEED              = 32'h9373;
  localparam int          RANDOM_COMMANDS   = 200;
  localparam int          DIRECTED_ACCESSES = 1000;
  // a random command needs at most six accesses, the seventh covers the idle gap
  localparam int          WATCHDOG_CYCLES   = 20 * (DIRECTED_ACCESSES + 7 * RANDOM_COMMANDS);

  typedef struct packed {
    word_t result;
    nzcv_t flags;
    logic  write_result;
    word_t latch;
  } prediction_t;

  typedef struct packed {
    logic                        is_flags;
    logic [`DP_WB_ADR_WIDTH-1:0] adr;
    word_t                       got;
    word_t                       exp;
  } read_item_t;

  logic        clk = 1'b0;
  logic        reset;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;

  word_t       m_op_a;
  word_t       m_op_b;
  word_t       m_result;
  word_t       m_latch;
  shift_ctrl_t m_shift;
  dp_cmd_t     m_cmd;
  nzcv_t       m_flags;

  read_item_t  read_q[$];
  read_item_t  pending;
  event        read_posted;
  int          reads_posted;
  int          reads_compared;

  alu_op_e     logic_ops [6] = '{ALU_OP_MOV, ALU_OP_NOT, ALU_OP_AND, ALU_OP_XOR, ALU_OP_OR,
                                 ALU_OP_BIT_CLEAR};
  alu_op_e     arith_ops [6] = '{ALU_OP_ADD, ALU_OP_ADC, ALU_OP_SUB, ALU_OP_SBC,
                                 ALU_OP_SUB_REVERSED, ALU_OP_SBC_REVERSED};
  alu_op_e     flag_ops  [4] = '{ALU_OP_TEST, ALU_OP_TEST_EXCLUSIVE, ALU_OP_CMP, ALU_OP_CMP_NEG};
  word_t       corner_a  [4] = '{32'h7FFFFFFF, 32'h80000000, 32'h00000000, 32'hFFFFFFFF};
  word_t       corner_b  [4] = '{32'h00000001, 32'h00000001, 32'h00000000, 32'h80000000};

  dp_unit_top uut (
    .clk    (clk),
    .reset  (reset),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  always #5 clk = ~clk;

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_word(input logic [`DP_WB_ADR_WIDTH-1:0] adr, input word_t got,
                            input word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t ns: read of address %0d gave %08h, expected %08h",
                          $time, adr, got, exp));
    end
  endtask

  task automatic check_flags(input nzcv_t got, input nzcv_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t ns: FLAGS nzcv %04b, expected %04b", $time, got, exp));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // model of the datapath
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // returns {carry, value} of operand B after the immediate shift
  function automatic logic [32:0] shift_operand(input word_t b, input shift_ctrl_t s,
                                                input logic c_in);
    int n;
    n = int'(s.amount);
    if (s.shift_type == SHIFT_RRX) return {b[0], c_in, b[31:1]};
    if (n == 0) return {c_in, b};
    case (s.shift_type)
      SHIFT_LSL: return {b[32-n], b << n};
      SHIFT_LSR: return {b[n-1], b >> n};
      SHIFT_ASR: return {b[n-1], $signed(b) >>> n};
      default:   return {b[n-1], (b >> n) | (b << (32 - n))};
    endcase
  endfunction

  function automatic prediction_t predict_cmd(input word_t a, input word_t b_raw,
                                              input shift_ctrl_t s, input dp_cmd_t cmd,
                                              input nzcv_t f, input word_t latch);
    logic [32:0] sh;
    logic [32:0] sum;
    word_t       b;
    word_t       x;
    word_t       y;
    logic        cin;
    logic        arith;
    prediction_t p;
    sh = shift_operand(b_raw, s, f.c);
    b = cmd.use_op_b_latch ? latch : (cmd.disable_op_b ? 32'h0 : sh[31:0]);
    p.latch = cmd.latch_op_b ? sh[31:0] : latch;
    p.flags = f;
    p.flags.c = sh[32];
    p.result = '0;
    x = a; // arithmetic is x + y + cin, subtraction adds the inverse
    y = b;
    cin = 1'b0;
    arith = 1'b1;
    case (cmd.alu_op)
      ALU_OP_MOV:                        p.result = b;
      ALU_OP_NOT:                        p.result = ~b;
      ALU_OP_AND, ALU_OP_TEST:           p.result = a & b;
      ALU_OP_XOR, ALU_OP_TEST_EXCLUSIVE: p.result = a ^ b;
      ALU_OP_OR:                         p.result = a | b;
      ALU_OP_BIT_CLEAR:                  p.result = a & ~b;
      ALU_OP_ADC:                        cin = f.c;
      ALU_OP_SUB, ALU_OP_CMP: begin
        y = ~b;
        cin = 1'b1;
      end
      ALU_OP_SBC: begin
        y = ~b;
        cin = f.c;
      end
      ALU_OP_SUB_REVERSED, ALU_OP_SBC_REVERSED: begin
        x = b;
        y = ~a;
        cin = (cmd.alu_op == ALU_OP_SUB_REVERSED) ? 1'b1 : f.c;
      end
      default: ; // ADD and CMP_NEG keep the plain sum
    endcase
    if (cmd.alu_op inside {[ALU_OP_MOV:ALU_OP_BIT_CLEAR]}) arith = 1'b0;
    if (arith) begin
      sum = {1'b0, x} + {1'b0, y} + {32'h0, cin};
      p.result = sum[31:0];
      p.flags.c = sum[32];
      p.flags.v = (x[31] == y[31]) && (p.result[31] != x[31]);
    end
    p.flags.n = p.result[31];
    p.flags.z = (p.result == 32'h0);
    p.write_result = !(cmd.alu_op inside {ALU_OP_TEST, ALU_OP_TEST_EXCLUSIVE, ALU_OP_CMP,
                                          ALU_OP_CMP_NEG});
    return p;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus master
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic bus_access(input logic we, input logic [`DP_WB_ADR_WIDTH-1:0] adr,
                            input word_t dat, output word_t rdata);
    int edges;
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    edges = 0;
    do begin
      @(posedge clk);
      edges++;
    end while (!wb_rsp.ack);
    rdata = wb_rsp.dat;
    wb_req <= '0;
    if (edges != 2) begin
      abort_run($sformatf("ERR %0t ns: ack seen %0d edges after the request, expected 2",
                          $time, edges));
    end
  endtask

  task automatic write_reg(input logic [`DP_WB_ADR_WIDTH-1:0] adr, input word_t dat);
    word_t       unused;
    prediction_t p;
    bus_access(1'b1, adr, dat, unused);
    case (adr)
      `DP_ADR_OP_A:  m_op_a = dat;
      `DP_ADR_OP_B:  m_op_b = dat;
      `DP_ADR_SHIFT: m_shift = shift_ctrl_t'(dat[7:0]);
      `DP_ADR_FLAGS: m_flags = nzcv_t'(dat[31:28]);
      `DP_ADR_CMD: begin
        m_cmd = dp_cmd_t'(dat[7:0]);
        p = predict_cmd(m_op_a, m_op_b, m_shift, m_cmd, m_flags, m_latch);
        if (p.write_result) m_result = p.result;
        m_flags = p.flags;
        m_latch = p.latch;
      end
      default: ;
    endcase
  endtask

  task automatic read_expect(input logic [`DP_WB_ADR_WIDTH-1:0] adr);
    word_t got;
    word_t exp;
    bus_access(1'b0, adr, 32'h0, got);
    case (adr)
      `DP_ADR_OP_A:   exp = m_op_a;
      `DP_ADR_OP_B:   exp = m_op_b;
      `DP_ADR_SHIFT:  exp = {24'h0, m_shift};
      `DP_ADR_CMD:    exp = {24'h0, m_cmd};
      `DP_ADR_RESULT: exp = m_result;
      `DP_ADR_FLAGS:  exp = {m_flags, 28'h0};
      default:        exp = 32'h0;
    endcase
    read_q.push_back('{is_flags: (adr == `DP_ADR_FLAGS), adr: adr, got: got, exp: exp});
    reads_posted++;
    -> read_posted;
  endtask

  task automatic set_operands(input word_t a, input word_t b, input shift_type_e st,
                              input logic [4:0] amount);
    write_reg(`DP_ADR_OP_A, a);
    write_reg(`DP_ADR_OP_B, b);
    write_reg(`DP_ADR_SHIFT, {24'h0, st, amount});
  endtask

  task automatic run_cmd(input alu_op_e op, input logic latch, input logic use_latch,
                         input logic dis);
    dp_cmd_t c;
    c = '{spare: 1'b0, disable_op_b: dis, use_op_b_latch: use_latch, latch_op_b: latch,
          alu_op: op};
    write_reg(`DP_ADR_CMD, {24'h0, c});
    read_expect(`DP_ADR_RESULT);
    read_expect(`DP_ADR_FLAGS);
  endtask

  always @(read_posted) begin
    while (read_q.size() != 0) begin
      pending = read_q.pop_front();
      if (pending.is_flags) check_flags(nzcv_t'(pending.got[31:28]), nzcv_t'(pending.exp[31:28]));
      check_word(pending.adr, pending.got, pending.exp);
      reads_compared++;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run($sformatf("Timeout: the run did not finish within %0d clock cycles",
                        WATCHDOG_CYCLES));
  end

  initial begin
    void'($urandom(SEED));
    reset  <= 1'b1;
    wb_req <= '0;
    m_op_a = '0;
    m_op_b = '0;
    m_result = '0;
    m_latch = '0;
    m_shift = '0;
    m_cmd = '0;
    m_flags = '0;
    reads_posted = 0;
    reads_compared = 0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    read_expect(`DP_ADR_RESULT);
    read_expect(`DP_ADR_FLAGS);
    read_expect(3'd7); // unmapped

    foreach (logic_ops[i]) begin
      for (int st = 0; st < 5; st++) begin
        for (int k = 0; k < 2; k++) begin
          set_operands($urandom, $urandom, shift_type_e'(st), k ? $urandom_range(31, 1) : 0);
          write_reg(`DP_ADR_FLAGS, {4'($urandom), 28'h0});
          run_cmd(logic_ops[i], 1'b0, 1'b0, 1'b0);
        end
      end
    end

    foreach (arith_ops[i]) begin
      for (int cin = 0; cin < 2; cin++) begin
        for (int k = 0; k < 5; k++) begin
          if (k < 4) set_operands(corner_a[k], corner_b[k], SHIFT_LSL, 5'd0);
          else set_operands($urandom, $urandom, SHIFT_LSL, 5'd0);
          write_reg(`DP_ADR_FLAGS, {2'b00, cin[0], 1'b0, 28'h0});
          run_cmd(arith_ops[i], 1'b0, 1'b0, 1'b0);
        end
      end
    end

    foreach (flag_ops[i]) begin
      set_operands($urandom, $urandom, SHIFT_ROR, 5'd3);
      run_cmd(ALU_OP_MOV, 1'b0, 1'b0, 1'b0); // gives RESULT a known value
      set_operands(corner_a[i], corner_b[i], SHIFT_LSL, 5'd0);
      run_cmd(flag_ops[i], 1'b0, 1'b0, 1'b0);
    end

    set_operands(32'h12345678, 32'h0F0F00F1, SHIFT_LSL, 5'd4);
    run_cmd(ALU_OP_MOV, 1'b1, 1'b0, 1'b0);
    write_reg(`DP_ADR_OP_B, 32'hDEADBEEF);
    run_cmd(ALU_OP_ADD, 1'b0, 1'b1, 1'b0);
    run_cmd(ALU_OP_AND, 1'b1, 1'b1, 1'b0); // uses the old latch, stores a new one
    run_cmd(ALU_OP_XOR, 1'b0, 1'b1, 1'b0);
    run_cmd(ALU_OP_SUB, 1'b0, 1'b0, 1'b1);
    run_cmd(ALU_OP_OR, 1'b0, 1'b0, 1'b1);

    // host registers now hold distinct values, so a wrong read decode shows up
    read_expect(`DP_ADR_OP_A);
    read_expect(`DP_ADR_OP_B);
    read_expect(`DP_ADR_SHIFT);
    read_expect(`DP_ADR_CMD);

    repeat (RANDOM_COMMANDS) begin
      if ($urandom_range(1, 0)) write_reg(`DP_ADR_OP_A, $urandom);
      if ($urandom_range(1, 0)) write_reg(`DP_ADR_OP_B, $urandom);
      if ($urandom_range(1, 0)) begin
        write_reg(`DP_ADR_SHIFT, {24'h0, 3'($urandom_range(4, 0)), 5'($urandom)});
      end
      repeat ($urandom_range(3, 0)) @(posedge clk);
      run_cmd(alu_op_e'($urandom_range(15, 0)), $urandom_range(3, 0) == 0,
              $urandom_range(3, 0) == 0, $urandom_range(3, 0) == 0);
    end

    @(posedge clk);
    if (reads_compared == reads_posted && read_q.size() == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      abort_run("Some reads were never compared against the model");
    end
  end

endmodule : dp_unit_tb

`default_nettype wire

//--- project.f
+incdir+include
verilog/dp_pkg.sv
verilog/barrel_shifter.sv
verilog/alu.sv
verilog/dp_wb_regs.sv
verilog/dp_unit_top.sv
sim/dp_unit_tb.sv

//--- Bender.yml
package:
  name: dp_unit

sources:
  - include_dirs:
      - include
    files:
      - verilog/dp_pkg.sv
      - verilog/barrel_shifter.sv
      - verilog/alu.sv
      - verilog/dp_wb_regs.sv
      - verilog/dp_unit_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - sim/dp_unit_tb.sv
